//--- pmp_unit.f
src/pmp_csr_pkg.sv
src/pmp_mem_pkg.sv
src/pmp_csr_file.sv
src/pmp_region_match.sv
src/pmp_checker.sv
src/pmp_unit.sv
tests/pmp_unit_tb.sv

//--- Bender.yml
package:
  name: pmp_unit

sources:
  - src/pmp_csr_pkg.sv
  - src/pmp_mem_pkg.sv
  - src/pmp_csr_file.sv
  - src/pmp_region_match.sv
  - src/pmp_checker.sv
  - src/pmp_unit.sv
  - target: test
    files:
      - tests/pmp_unit_tb.sv

//--- tests/pmp_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pmp_unit_tb;

  typedef enum int {row_write, row_read, row_check} row_kind_e;

  typedef struct {
    row_kind_e               kind;
    pmp_csr_pkg::csr_addr_t  addr;
    logic [31:0]             data;
    pmp_mem_pkg::mem_req_t   req;
    int                      stall; // cycles rsp_ready stays low.
    logic [31:0]             exp_rdata;
    pmp_mem_pkg::check_rsp_t exp_rsp;
  } row_t;

  localparam int acc_load  = 0;
  localparam int acc_store = 1;
  localparam int acc_fetch = 2;
  localparam pmp_mem_pkg::priv_e priv_u = pmp_mem_pkg::u_mode;
  localparam pmp_mem_pkg::priv_e priv_s = pmp_mem_pkg::s_mode;
  localparam pmp_mem_pkg::priv_e priv_m = pmp_mem_pkg::m_mode;
  localparam pmp_csr_pkg::csr_addr_t cfg0 = pmp_csr_pkg::pmpcfg0_addr;

  logic                       clk;
  logic                       rst;
  pmp_csr_pkg::csr_write_t    csr_wr;
  pmp_csr_pkg::csr_addr_t     csr_raddr;
  logic [31:0]                csr_rdata;
  pmp_mem_pkg::mem_req_t      req;
  logic                       req_valid;
  logic                       req_ready;
  pmp_mem_pkg::check_rsp_t    rsp;
  logic                       rsp_valid;
  logic                       rsp_ready;

  row_t                       rows[$];
  row_t                       exp_q[$]; // accepted checks awaiting a response.
  pmp_csr_pkg::pmpcfg_entry_t sh_cfg[4];
  logic [31:0]                sh_addr[4];
  int                         seed = 32'ha075_ea5a;
  bit                         table_ready = 1'b0;

  pmp_unit UUT (
    .clk      (clk),
    .rst      (rst),
    .csr_wr   (csr_wr),
    .csr_raddr(csr_raddr),
    .csr_rdata(csr_rdata),
    .req      (req),
    .req_valid(req_valid),
    .req_ready(req_ready),
    .rsp      (rsp),
    .rsp_valid(rsp_valid),
    .rsp_ready(rsp_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_rdata(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) abort_run($sformatf("mismatch %s: expected 0x%h, got 0x%h", name, exp, got));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) abort_run($sformatf("mismatch %s: expected 0x%h, got 0x%h", name, exp, got));
  endtask

  task automatic check_rsp(input string name, input pmp_mem_pkg::check_rsp_t got,
                           input pmp_mem_pkg::check_rsp_t exp);
    check_flag({name, ".fault"}, got.fault, exp.fault);
    check_rdata({name, ".cause"}, 32'(got.cause), 32'(exp.cause));
    check_rdata({name, ".tval"}, got.tval, exp.tval);
  endtask

  function automatic pmp_csr_pkg::csr_addr_t pmpaddr_csr(input int i);
    return pmp_csr_pkg::csr_addr_t'(pmp_csr_pkg::pmpaddr0_addr + i);
  endfunction

  // shadow of the csr lock rules.
  function automatic void shadow_write(input pmp_csr_pkg::csr_addr_t a, input logic [31:0] d);
    logic top_tor_lock;
    for (int i = 0; i < 4; i++) begin
      if (a == cfg0 && !sh_cfg[i].l) begin
        sh_cfg[i]      = d[8*i +: 8];
        sh_cfg[i].rsvd = 2'b00;
      end
    end
    for (int i = 0; i < 4; i++) begin
      top_tor_lock = 1'b0;
      if (i < 3) top_tor_lock = sh_cfg[i+1].l && sh_cfg[i+1].a == pmp_csr_pkg::tor;
      if (a == pmpaddr_csr(i) && !sh_cfg[i].l && !top_tor_lock) sh_addr[i] = d;
    end
  endfunction

  function automatic logic [31:0] shadow_read(input pmp_csr_pkg::csr_addr_t a);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < 4; i++) begin
      if (a == cfg0) v[8*i +: 8] = sh_cfg[i];
      if (a == pmpaddr_csr(i)) v = sh_addr[i];
    end
    return v;
  endfunction

  function automatic logic region_hit(input int i, input logic [31:0] addr);
    logic [35:0] a36;
    logic [35:0] lo;
    logic [35:0] size;
    logic [35:0] base;
    int          t;
    a36 = {4'h0, addr};
    case (sh_cfg[i].a)
      pmp_csr_pkg::tor: begin
        lo = '0;
        if (i > 0) lo = {2'b00, sh_addr[i-1], 2'b00};
        return a36 >= lo && a36 < {2'b00, sh_addr[i], 2'b00};
      end
      pmp_csr_pkg::na4: return addr[31:2] == sh_addr[i][29:0];
      pmp_csr_pkg::napot: begin
        t = 0;
        while (t < 32 && sh_addr[i][t]) t++;
        if (t == 32) return 1'b1;
        size = 36'd1 << (t + 3); // region bytes.
        base = {2'b00, sh_addr[i], 2'b00} & ~(size - 36'd1);
        return a36 >= base && a36 < base + size;
      end
      default: return 1'b0;
    endcase
  endfunction

  function automatic pmp_mem_pkg::check_rsp_t ref_check(input pmp_mem_pkg::mem_req_t r);
    pmp_mem_pkg::check_rsp_t res;
    int   sel;
    logic perm;
    logic allow;
    sel = -1;
    for (int i = 3; i >= 0; i--) begin
      if (region_hit(i, r.addr)) sel = i;
    end
    allow = (r.priv == pmp_mem_pkg::m_mode);
    if (sel >= 0) begin
      perm  = r.instr ? sh_cfg[sel].x : (|r.wstrb ? sh_cfg[sel].w : sh_cfg[sel].r);
      allow = perm || (r.priv == pmp_mem_pkg::m_mode && !sh_cfg[sel].l);
    end
    res = '0;
    if (!allow) begin
      res.fault = 1'b1;
      res.tval  = r.addr;
      res.cause = r.instr ? pmp_mem_pkg::cause_instr_fault
                : (|r.wstrb ? pmp_mem_pkg::cause_store_fault : pmp_mem_pkg::cause_load_fault);
    end
    return res;
  endfunction

  task automatic add_write(input pmp_csr_pkg::csr_addr_t a, input logic [31:0] d);
    row_t r;
    r      = '{kind: row_write, default: '0};
    r.addr = a;
    r.data = d;
    shadow_write(a, d);
    rows.push_back(r);
  endtask

  task automatic add_read(input pmp_csr_pkg::csr_addr_t a);
    row_t r;
    r           = '{kind: row_read, default: '0};
    r.addr      = a;
    r.exp_rdata = shadow_read(a);
    rows.push_back(r);
  endtask

  task automatic add_check(input logic [31:0] a, input int acc, input pmp_mem_pkg::priv_e p,
                           input int stall);
    row_t r;
    r         = '{kind: row_check, default: '0};
    r.req     = '{addr: a, instr: acc == acc_fetch, wstrb: 4'h0, priv: p};
    if (acc == acc_store) r.req.wstrb = 4'b0001 << a[1:0]; // byte store.
    r.stall   = stall;
    r.exp_rsp = ref_check(r.req);
    rows.push_back(r);
  endtask

  task automatic build_table;
    logic [31:0] rnd;
    for (int i = 0; i < 4; i++) begin
      sh_cfg[i]  = '0;
      sh_addr[i] = '0;
    end
    add_write(cfg0, 32'h7F7F_7F7F); // reserved bits must drop.
    add_read(cfg0);
    add_write(pmpaddr_csr(0), 32'h0000_0400);
    add_write(pmpaddr_csr(1), 32'h0000_0800);
    add_write(pmpaddr_csr(2), 32'h0000_0C03); // napot 32 bytes at 0x3000.
    add_write(pmpaddr_csr(3), 32'h0000_03FF); // napot 8 KiB at 0.
    for (int i = 0; i < 4; i++) add_read(pmpaddr_csr(i));
    add_read(12'h3A1);
    add_read(12'h7C0);
    add_write(cfg0, 32'h001C_1309); // tor r, na4 rw, napot x, entry 3 off.
    add_check(32'h0000_0FFC, acc_load, priv_u, 0);
    add_check(32'h0000_1000, acc_load, priv_u, 0);
    add_check(32'h0000_0010, acc_store, priv_u, 3);
    add_check(32'h0000_0800, acc_fetch, priv_u, 0);
    add_check(32'h0000_2000, acc_store, priv_u, 0);
    add_check(32'h0000_2003, acc_load, priv_u, 0);
    add_check(32'h0000_2004, acc_store, priv_u, 2);
    add_check(32'h0000_2000, acc_fetch, priv_u, 0);
    add_check(32'h0000_3000, acc_fetch, priv_u, 0);
    add_check(32'h0000_301C, acc_fetch, priv_u, 0);
    add_check(32'h0000_3020, acc_fetch, priv_u, 0);
    add_check(32'h0000_2FFC, acc_fetch, priv_u, 0);
    add_check(32'h0000_3010, acc_load, priv_u, 1);
    add_write(cfg0, 32'h1F1C_1309); // entry 3 overlaps entry 0 with rwx.
    add_check(32'h0000_0100, acc_store, priv_u, 0);
    add_check(32'h0000_1800, acc_store, priv_u, 0);
    add_check(32'h0000_0100, acc_store, priv_m, 0);
    add_check(32'h8000_0000, acc_load, priv_m, 0);
    add_check(32'h8000_0000, acc_load, priv_s, 2);
    add_write(cfg0, 32'h1F1C_1389);
    add_check(32'h0000_0100, acc_store, priv_m, 0);
    add_check(32'h0000_0100, acc_load, priv_m, 0);
    add_write(cfg0, 32'h1F1C_170F);
    add_read(cfg0);
    add_write(pmpaddr_csr(0), 32'h0000_0123);
    add_write(cfg0, 32'h891C_170F); // entry 3 becomes a locked tor top.
    add_write(pmpaddr_csr(1), 32'h0000_0900);
    add_write(pmpaddr_csr(2), 32'h0000_0555);
    add_write(pmpaddr_csr(3), 32'h0000_0777);
    for (int i = 0; i < 4; i++) add_read(pmpaddr_csr(i));
    add_read(cfg0);
    for (int n = 0; n < 8; n++) begin
      rnd = $random(seed);
      add_check(rnd & 32'h0000_3FFF, int'(rnd[17:16]) % 3, rnd[18] ? priv_m : priv_u,
                int'(rnd[21:20]));
    end
  endtask

  task automatic drain_responses;
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > 20) abort_run("no response arrived within 20 cycles");
    end
  endtask

  task automatic issue_check(input row_t r);
    logic ready;
    int   waited;
    waited    = 0;
    req       = r.req;
    req_valid = 1'b1;
    exp_q.push_back(r);
    forever begin
      #4;
      ready = req_ready; // mid-cycle sample.
      @(posedge clk);
      #1;
      if (ready) break;
      waited++;
      if (waited >= 20) abort_run("request was not accepted within 20 cycles");
    end
    req_valid = 1'b0;
  endtask

  initial begin : collect_responses
    int stall_left;
    bit loaded;
    stall_left = 0;
    loaded     = 1'b0;
    wait (rst === 1'b1);
    forever begin
      @(posedge clk);
      #1;
      if (rsp_valid === 1'b1) begin
        if (exp_q.size() == 0) abort_run("response appeared with no request outstanding");
        if (!loaded) begin
          stall_left = exp_q[0].stall;
          loaded     = 1'b1;
        end
        check_rsp("rsp", rsp, exp_q[0].exp_rsp);
        if (stall_left > 0) begin
          rsp_ready = 1'b0;
          stall_left--;
          #1;
          check_flag("req_ready", req_ready, 1'b0);
        end else begin
          rsp_ready = 1'b1; // transfer at the next edge.
          void'(exp_q.pop_front());
          loaded = 1'b0;
        end
      end else begin
        rsp_ready = 1'b1;
      end
    end
  end

  initial begin : watchdog
    wait (table_ready);
    repeat (rows.size() * 30) @(posedge clk);
    abort_run("watchdog expired before the table finished");
  end

  initial begin
    rst       = 1'b0;
    csr_wr    = '0;
    csr_raddr = '0;
    req       = '0;
    req_valid = 1'b0;
    rsp_ready = 1'b1;
    build_table();
    table_ready = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b1;
    foreach (rows[n]) begin
      case (rows[n].kind)
        row_write: begin
          drain_responses();
          csr_wr = '{en: 1'b1, addr: rows[n].addr, data: rows[n].data};
          @(posedge clk);
          #1;
          csr_wr.en = 1'b0;
        end
        row_read: begin
          drain_responses();
          csr_raddr = rows[n].addr;
          #2;
          check_rdata("csr_rdata", csr_rdata, rows[n].exp_rdata);
          @(posedge clk);
          #1;
        end
        default: issue_check(rows[n]);
      endcase
    end
    drain_responses();
    repeat (2) @(posedge clk); // a repeated response would show here.
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- src/pmp_unit.sv
`timescale 1ns/1ps
`default_nettype none

module pmp_unit #(
  parameter int num_entries = 4,
  parameter bit pmp_enable  = 1'b1
) (
  input  logic                    clk,
  input  logic                    rst,
  input  pmp_csr_pkg::csr_write_t csr_wr,
  input  pmp_csr_pkg::csr_addr_t  csr_raddr,
  output logic [31:0]             csr_rdata,
  input  pmp_mem_pkg::mem_req_t   req,
  input  logic                    req_valid,
  output logic                    req_ready,
  output pmp_mem_pkg::check_rsp_t rsp,
  output logic                    rsp_valid,
  input  logic                    rsp_ready
);

  pmp_csr_pkg::pmpcfg_entry_t [num_entries-1:0] cfg;
  logic [num_entries-1:0][31:0]                pmpaddr;
  logic [num_entries:0][31:0]                  bounds;
  logic [num_entries-1:0]                      hits;

  // bounds[i] is the tor floor of entry i, zero below entry 0.
  assign bounds = {pmpaddr, 32'h0};

  pmp_csr_file #(
    .num_entries(num_entries)
  ) u_csr_file (
    .clk      (clk),
    .rst      (rst),
    .csr_wr   (csr_wr),
    .csr_raddr(csr_raddr),
    .csr_rdata(csr_rdata),
    .cfg      (cfg),
    .pmpaddr  (pmpaddr)
  );

  for (genvar i = 0; i < num_entries; i++) begin : g_match
    pmp_region_match u_match (
      .cfg       (cfg[i]),
      .pmpaddr_lo(bounds[i]),
      .pmpaddr_hi(bounds[i+1]),
      .addr      (req.addr),
      .hit       (hits[i])
    );
  end

  pmp_checker #(
    .num_entries(num_entries),
    .pmp_enable (pmp_enable)
  ) u_checker (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .req_valid(req_valid),
    .req_ready(req_ready),
    .cfg      (cfg),
    .hits     (hits),
    .rsp      (rsp),
    .rsp_valid(rsp_valid),
    .rsp_ready(rsp_ready)
  );

endmodule

`default_nettype wire

//--- src/pmp_checker.sv
`timescale 1ns/1ps
`default_nettype none

module pmp_checker #(
  parameter int num_entries = 4,
  parameter bit pmp_enable  = 1'b1
) (
  input  logic                                        clk,
  input  logic                                        rst,
  input  pmp_mem_pkg::mem_req_t                       req,
  input  logic                                        req_valid,
  output logic                                        req_ready,
  input  pmp_csr_pkg::pmpcfg_entry_t [num_entries-1:0] cfg,
  input  logic [num_entries-1:0]                      hits,
  output pmp_mem_pkg::check_rsp_t                     rsp,
  output logic                                        rsp_valid,
  input  logic                                        rsp_ready
);

  logic                       is_fetch;
  logic                       is_store;
  logic                       found;
  pmp_csr_pkg::pmpcfg_entry_t sel_cfg;
  logic                       perm;
  logic                       is_m;
  logic                       pass;
  pmp_mem_pkg::check_rsp_t    rsp_d;
  logic                       accept;

  assign is_fetch = req.instr;
  assign is_store = !req.instr && (|req.wstrb);
  assign is_m     = (req.priv == pmp_mem_pkg::m_mode);

  // walk down so the lowest hit wins.
  always_comb begin
    found   = 1'b0;
    sel_cfg = '0;
    for (int i = num_entries - 1; i >= 0; i--) begin
      if (hits[i]) begin
        found   = 1'b1;
        sel_cfg = cfg[i];
      end
    end
  end

  always_comb begin
    if (is_fetch) begin
      perm = sel_cfg.x;
    end else if (is_store) begin
      perm = sel_cfg.w;
    end else begin
      perm = sel_cfg.r;
    end

    if (found) begin
      pass = perm || (!sel_cfg.l && is_m); // unlocked entries bind only below m-mode.
    end else begin
      pass = is_m;
    end
    if (!pmp_enable) begin
      pass = 1'b1;
    end

    rsp_d = '0;
    if (!pass) begin
      rsp_d.fault = 1'b1;
      rsp_d.tval  = req.addr;
      if (is_fetch) begin
        rsp_d.cause = pmp_mem_pkg::cause_instr_fault;
      end else if (is_store) begin
        rsp_d.cause = pmp_mem_pkg::cause_store_fault;
      end else begin
        rsp_d.cause = pmp_mem_pkg::cause_load_fault;
      end
    end
  end

  assign req_ready = !rsp_valid || rsp_ready;
  assign accept    = req_valid && req_ready;

  always_ff @(posedge clk) begin
    if (!rst) begin
      rsp_valid <= 1'b0;
    end else if (accept) begin
      rsp_valid <= 1'b1;
    end else if (rsp_ready) begin
      rsp_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rsp <= rsp_d;
    end
  end

  a_rsp_held : assert property (
    @(posedge clk) disable iff (!rst)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp)
  );

  a_rsp_source : assert property (
    @(posedge clk) disable iff (!rst)
    rsp_valid |-> $past(accept || (rsp_valid && !rsp_ready))
  );

endmodule

`default_nettype wire

//--- src/pmp_region_match.sv
`timescale 1ns/1ps
`default_nettype none

module pmp_region_match (
  input  pmp_csr_pkg::pmpcfg_entry_t cfg,
  input  logic [31:0]                pmpaddr_lo,
  input  logic [31:0]                pmpaddr_hi,
  input  logic [31:0]                addr,
  output logic                       hit
);

  logic [33:0] byte_addr;
  logic [33:0] tor_lo;
  logic [33:0] tor_hi;
  logic [31:0] word_addr;
  logic [31:0] napot_care;

  // compare on 34 bits so pmpaddr*4 cannot wrap.
  assign byte_addr = {2'b00, addr};
  assign tor_lo    = {pmpaddr_lo, 2'b00};
  assign tor_hi    = {pmpaddr_hi, 2'b00};
  assign word_addr = {2'b00, addr[31:2]};

  // ones over the trailing ones and the first zero, i.e. the low t+1 bits.
  // all ones when pmpaddr is all ones, so every address matches.
  assign napot_care = pmpaddr_hi ^ (pmpaddr_hi + 32'd1);

  always_comb begin
    hit = 1'b0;
    case (cfg.a)
      pmp_csr_pkg::tor: begin
        hit = (byte_addr >= tor_lo) && (byte_addr < tor_hi);
      end
      pmp_csr_pkg::na4: begin
        hit = (addr[31:2] == pmpaddr_hi[29:0]);
      end
      pmp_csr_pkg::napot: begin
        hit = ((word_addr & ~napot_care) == (pmpaddr_hi & ~napot_care));
      end
      default: begin
        hit = 1'b0; // off.
      end
    endcase
  end

endmodule

`default_nettype wire

//--- src/pmp_csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module pmp_csr_file #(
  parameter int num_entries = 4
) (
  input  logic                                        clk,
  input  logic                                        rst,
  input  pmp_csr_pkg::csr_write_t                     csr_wr,
  input  pmp_csr_pkg::csr_addr_t                      csr_raddr,
  output logic [31:0]                                 csr_rdata,
  output pmp_csr_pkg::pmpcfg_entry_t [num_entries-1:0] cfg,
  output logic [num_entries-1:0][31:0]                pmpaddr
);

  pmp_csr_pkg::pmpcfg_word_u wr_word;
  pmp_csr_pkg::pmpcfg_word_u rd_word;
  logic [num_entries-1:0]    addr_locked;
  logic [3:0]                wr_sel;
  logic [3:0]                rd_sel;

  function automatic logic [3:0] pmpaddr_onehot(input pmp_csr_pkg::csr_addr_t a);
    case (a)
      pmp_csr_pkg::pmpaddr0_addr: return 4'b0001;
      pmp_csr_pkg::pmpaddr1_addr: return 4'b0010;
      pmp_csr_pkg::pmpaddr2_addr: return 4'b0100;
      pmp_csr_pkg::pmpaddr3_addr: return 4'b1000;
      default:                    return 4'b0000;
    endcase
  endfunction

  assign wr_word.raw = csr_wr.data;
  assign wr_sel      = pmpaddr_onehot(csr_wr.addr);
  assign rd_sel      = pmpaddr_onehot(csr_raddr);

  // pmpaddr i also freezes when entry i+1 is a locked tor top.
  always_comb begin
    for (int i = 0; i < num_entries; i++) begin
      addr_locked[i] = cfg[i].l;
    end
    for (int i = 1; i < num_entries; i++) begin
      if (cfg[i].l && cfg[i].a == pmp_csr_pkg::tor) begin
        addr_locked[i-1] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      cfg     <= '0;
      pmpaddr <= '0;
    end else if (csr_wr.en) begin
      for (int i = 0; i < num_entries; i++) begin
        if (csr_wr.addr == pmp_csr_pkg::pmpcfg0_addr && !cfg[i].l) begin
          cfg[i] <= '{
            l:    wr_word.entry[i].l,
            rsvd: 2'b00,
            a:    wr_word.entry[i].a,
            x:    wr_word.entry[i].x,
            w:    wr_word.entry[i].w,
            r:    wr_word.entry[i].r
          };
        end
        if (wr_sel[i] && !addr_locked[i]) begin
          pmpaddr[i] <= csr_wr.data;
        end
      end
    end
  end

  always_comb begin
    rd_word.raw = '0; // unimplemented entries read zero.
    for (int i = 0; i < num_entries; i++) begin
      rd_word.entry[i] = cfg[i];
    end
  end

  always_comb begin
    csr_rdata = '0;
    if (csr_raddr == pmp_csr_pkg::pmpcfg0_addr) begin
      csr_rdata = rd_word.raw;
    end
    for (int i = 0; i < num_entries; i++) begin
      if (rd_sel[i]) begin
        csr_rdata = pmpaddr[i];
      end
    end
  end

  for (genvar g = 0; g < num_entries; g++) begin : g_lock_chk
    a_locked_cfg_stable : assert property (
      @(posedge clk) disable iff (!rst)
      cfg[g].l |=> $stable(cfg[g])
    );
  end

endmodule

`default_nettype wire

//--- src/pmp_mem_pkg.sv
`default_nettype none

package pmp_mem_pkg;

  typedef enum logic [1:0] {
    u_mode = 2'd0,
    s_mode = 2'd1,
    m_mode = 2'd3
  } priv_e;

  // instr set means fetch; otherwise any strobe means store.
  typedef struct packed {
    logic [31:0] addr;
    logic        instr;
    logic [3:0]  wstrb;
    priv_e       priv;
  } mem_req_t;

  localparam logic [3:0] cause_instr_fault = 4'd1;
  localparam logic [3:0] cause_load_fault  = 4'd5;
  localparam logic [3:0] cause_store_fault = 4'd7;

  typedef struct packed {
    logic        fault;
    logic [3:0]  cause; // zero when no fault.
    logic [31:0] tval;  // faulting address.
  } check_rsp_t;

endpackage

`default_nettype wire

//--- src/pmp_csr_pkg.sv
`default_nettype none

package pmp_csr_pkg;

  typedef logic [11:0] csr_addr_t;

  localparam csr_addr_t pmpcfg0_addr  = 12'h3A0;
  localparam csr_addr_t pmpaddr0_addr = 12'h3B0;
  localparam csr_addr_t pmpaddr1_addr = 12'h3B1;
  localparam csr_addr_t pmpaddr2_addr = 12'h3B2;
  localparam csr_addr_t pmpaddr3_addr = 12'h3B3;

  typedef enum logic [1:0] {
    off   = 2'd0,
    tor   = 2'd1,
    na4   = 2'd2,
    napot = 2'd3
  } pmp_mode_e;

  typedef struct packed {
    logic      l;
    logic [1:0] rsvd; // reads as zero.
    pmp_mode_e a;
    logic      x;
    logic      w;
    logic      r;
  } pmpcfg_entry_t;

  // entry i sits in bits 8i+7..8i of the csr word.
  typedef union packed {
    logic [31:0]             raw;
    pmpcfg_entry_t [3:0]     entry;
  } pmpcfg_word_u;

  typedef struct packed {
    logic        en;
    csr_addr_t   addr;
    logic [31:0] data;
  } csr_write_t;

endpackage

`default_nettype wire
